// File: filelist.f
rtl/ipv4_pkg.sv
rtl/rx_buffer_pkg.sv
rtl/slot_if.sv
rtl/synchronous_fifo.sv
rtl/receive_slot.sv
rtl/slot_write_steer.sv
rtl/slot_drain_arbiter.sv
rtl/ipv4_receive_buffer.sv
sim/tb_ipv4_receive_buffer.sv

// File: rtl/ipv4_pkg.sv
package ipv4_pkg;

    ////////////////////////////////////////
    // IPv4 header words seen by the buffer
    ////////////////////////////////////////

    // Identification word, carried through untouched
    typedef logic [15:0] ipv4_ident_t;

    // Flags and fragment offset share one header word
    // Bit 15 is the reserved bit and must be zero on the wire
    typedef union packed {
        // Whole word as it came off the header
        logic [15:0] raw;

        // Field view, most significant bit first
        struct packed {
            // Evil bit, packets with it set get dropped
            logic        reserved;
            logic        dont_fragment;
            logic        more_fragments;
            // Offset in units of eight bytes
            logic [12:0] fragment_offset;
        } fields;
    } ipv4_flags_u;

endpackage

// File: rtl/ipv4_receive_buffer.sv
module ipv4_receive_buffer #(
    parameter int NUM_SLOTS  = 4,
    parameter int SLOT_DEPTH = 64
) (
    input  logic                    clock,
    input  logic                    reset_n,

    // Byte stream and verdicts from the parser
    input  rx_buffer_pkg::rx_byte_t in_data,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    in_good,
    input  logic                    in_bad,
    input  ipv4_pkg::ipv4_flags_u   in_flags,
    input  ipv4_pkg::ipv4_ident_t   in_identification,

    // Committed packets, one after another
    output rx_buffer_pkg::rx_byte_t out_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    out_last,
    output ipv4_pkg::ipv4_flags_u   out_flags,
    output ipv4_pkg::ipv4_ident_t   out_identification
);

    slot_if slots [NUM_SLOTS] ();

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        receive_slot #(
            .SLOT_DEPTH (SLOT_DEPTH)
        ) i_receive_slot (
            .clock   (clock),
            .reset_n (reset_n),
            .port    (slots[i])
        );
    end

    slot_write_steer #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_slot_write_steer (
        .clock             (clock),
        .reset_n           (reset_n),
        .in_data           (in_data),
        .in_valid          (in_valid),
        .in_good           (in_good),
        .in_bad            (in_bad),
        .in_flags          (in_flags),
        .in_identification (in_identification),
        .in_ready          (in_ready),
        .slots             (slots)
    );

    slot_drain_arbiter #(
        .NUM_SLOTS (NUM_SLOTS)
    ) i_slot_drain_arbiter (
        .clock              (clock),
        .reset_n            (reset_n),
        .slots              (slots),
        .out_data           (out_data),
        .out_valid          (out_valid),
        .out_last           (out_last),
        .out_flags          (out_flags),
        .out_identification (out_identification),
        .out_ready          (out_ready)
    );

endmodule

// File: rtl/receive_slot.sv
module receive_slot #(
    parameter int  SLOT_DEPTH  = 64,
    localparam int COUNT_WIDTH = $clog2(SLOT_DEPTH) + 1
) (
    input logic clock,
    input logic reset_n,
    slot_if.slot port
);

    rx_buffer_pkg::slot_state_e state;
    rx_buffer_pkg::slot_state_e next_state;

    logic                   slot_ready;
    logic                   fifo_flush;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic [COUNT_WIDTH-1:0] fifo_count;

    synchronous_fifo #(
        .DEPTH (SLOT_DEPTH)
    ) i_synchronous_fifo (
        .clock        (clock),
        .reset_n      (reset_n),
        .flush        (fifo_flush),
        .write_enable (port.write_enable),
        .write_data   (port.write_data),
        .read_enable  (port.pop),
        .read_data    (port.read_data),
        .read_valid   (port.read_valid),
        .full         (fifo_full),
        .empty        (fifo_empty),
        .count        (fifo_count)
    );

    ////////////////////////////////////////
    // Slot FSM
    ////////////////////////////////////////

    always_comb begin
        next_state = state;
        fifo_flush = 1'b0;
        case (state)
            rx_buffer_pkg::SLOT_IDLE: begin
                // An empty good packet has nothing to drain
                if (port.good_packet && !fifo_empty) begin
                    next_state = rx_buffer_pkg::SLOT_DRAINING;
                end
                if (port.bad_packet) begin
                    fifo_flush = 1'b1;
                end
            end
            rx_buffer_pkg::SLOT_DRAINING: begin
                if (fifo_empty) begin
                    next_state = rx_buffer_pkg::SLOT_IDLE;
                end
            end
            default: begin
                next_state = rx_buffer_pkg::SLOT_IDLE;
            end
        endcase
    end

    // Ready follows the state, but stays low for the first cycle out of reset
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state      <= rx_buffer_pkg::SLOT_IDLE;
            slot_ready <= 1'b0;
        end else begin
            state      <= next_state;
            slot_ready <= (next_state == rx_buffer_pkg::SLOT_IDLE);
        end
    end

    // Header words of the packet being committed
    always_ff @(posedge clock) begin
        if (state == rx_buffer_pkg::SLOT_IDLE && port.good_packet) begin
            port.current_flags          <= port.flags;
            port.current_identification <= port.identification;
        end
    end

    assign port.ready      = slot_ready;
    assign port.full       = fifo_full;
    assign port.data_ready = (state == rx_buffer_pkg::SLOT_DRAINING);
    assign port.last       = (fifo_count == COUNT_WIDTH'(1));

    // Steerer moves on once a packet is committed here
    assert property (@(posedge clock) disable iff (!reset_n)
        port.write_enable |-> state == rx_buffer_pkg::SLOT_IDLE);

endmodule

// File: rtl/rx_buffer_pkg.sv
package rx_buffer_pkg;

    ////////////////////////////////////////
    // Buffer side types
    ////////////////////////////////////////

    // One payload byte
    typedef logic [7:0] rx_byte_t;

    // Slot FSM
    // Idle covers both empty and filling, the slot accepts bytes
    // Draining holds a committed packet until the FIFO runs dry
    typedef enum logic {
        SLOT_IDLE,
        SLOT_DRAINING
    } slot_state_e;

endpackage

// File: rtl/slot_drain_arbiter.sv
module slot_drain_arbiter #(
    parameter int  NUM_SLOTS   = 4,
    localparam int INDEX_WIDTH = $clog2(NUM_SLOTS),
    localparam int COUNT_WIDTH = $clog2(NUM_SLOTS + 1)
) (
    input  logic                    clock,
    input  logic                    reset_n,
    slot_if.drain                   slots [NUM_SLOTS],
    output rx_buffer_pkg::rx_byte_t out_data,
    output logic                    out_valid,
    output logic                    out_last,
    output ipv4_pkg::ipv4_flags_u   out_flags,
    output ipv4_pkg::ipv4_ident_t   out_identification,
    input  logic                    out_ready
);

    rx_buffer_pkg::rx_byte_t slot_data     [NUM_SLOTS];
    ipv4_pkg::ipv4_flags_u   slot_flags    [NUM_SLOTS];
    ipv4_pkg::ipv4_ident_t   slot_ident    [NUM_SLOTS];
    logic [INDEX_WIDTH-1:0]  order_queue   [NUM_SLOTS];

    logic [NUM_SLOTS-1:0]    slot_committed;
    logic [NUM_SLOTS-1:0]    committed_q;
    logic [NUM_SLOTS-1:0]    commit_rise;
    logic [NUM_SLOTS-1:0]    slot_valid;
    logic [NUM_SLOTS-1:0]    slot_last;
    logic [INDEX_WIDTH-1:0]  push_index;
    logic [INDEX_WIDTH-1:0]  write_pointer;
    logic [INDEX_WIDTH-1:0]  read_pointer;
    logic [INDEX_WIDTH-1:0]  head;
    logic [COUNT_WIDTH-1:0]  queue_count;
    logic                    push;
    logic                    head_valid;
    logic                    pop_enable;
    logic                    retire;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign slot_committed[i] = slots[i].data_ready;
        assign slot_valid[i]     = slots[i].read_valid;
        assign slot_last[i]      = slots[i].last;
        assign slot_data[i]      = slots[i].read_data;
        assign slot_flags[i]     = slots[i].current_flags;
        assign slot_ident[i]     = slots[i].current_identification;
        assign slots[i].pop      = pop_enable && (head == INDEX_WIDTH'(i));
    end

    ////////////////////////////////////////
    // Commit-order queue
    ////////////////////////////////////////

    assign commit_rise = slot_committed & ~committed_q;

    // One verdict per cycle, so at most one slot commits at a time
    always_comb begin
        push       = 1'b0;
        push_index = '0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (commit_rise[i]) begin
                push       = 1'b1;
                push_index = INDEX_WIDTH'(i);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            order_queue[write_pointer] <= push_index;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            committed_q   <= '0;
            write_pointer <= '0;
            read_pointer  <= '0;
            queue_count   <= '0;
        end else begin
            committed_q <= slot_committed;
            if (push) begin
                write_pointer <= (write_pointer == INDEX_WIDTH'(NUM_SLOTS - 1)) ?
                                 '0 : write_pointer + 1'b1;
            end
            if (retire) begin
                read_pointer <= (read_pointer == INDEX_WIDTH'(NUM_SLOTS - 1)) ?
                                '0 : read_pointer + 1'b1;
            end
            queue_count <= queue_count + COUNT_WIDTH'(push) - COUNT_WIDTH'(retire);
        end
    end

    ////////////////////////////////////////
    // Output stream from the head slot
    ////////////////////////////////////////

    assign head       = order_queue[read_pointer];
    assign head_valid = (queue_count != '0);

    assign out_valid          = head_valid && slot_valid[head];
    assign out_last           = head_valid && slot_last[head];
    assign out_data           = slot_data[head];
    assign out_flags          = slot_flags[head];
    assign out_identification = slot_ident[head];

    assign pop_enable = out_valid && out_ready;
    // Head slot is done once its final byte has gone
    assign retire     = pop_enable && out_last;

    assert property (@(posedge clock) disable iff (!reset_n) $onehot0(commit_rise));

    assert property (@(posedge clock) disable iff (!reset_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last) &&
            $stable(out_flags) && $stable(out_identification));

endmodule

// File: rtl/slot_if.sv
interface slot_if;

    // Write side, from the steerer
    rx_buffer_pkg::rx_byte_t write_data;
    logic                    write_enable;
    logic                    good_packet;
    logic                    bad_packet;
    ipv4_pkg::ipv4_flags_u   flags;
    ipv4_pkg::ipv4_ident_t   identification;

    // Slot status back to the steerer
    logic                    ready;
    logic                    full;

    // Read side, towards the drain arbiter
    logic                    pop;
    rx_buffer_pkg::rx_byte_t read_data;
    logic                    read_valid;
    logic                    last;
    logic                    data_ready;
    ipv4_pkg::ipv4_flags_u   current_flags;
    ipv4_pkg::ipv4_ident_t   current_identification;

    modport steer (
        output write_data, write_enable, good_packet, bad_packet, flags, identification,
        input  ready, full
    );

    modport drain (
        output pop,
        input  read_data, read_valid, last, data_ready, current_flags,
        input  current_identification
    );

    modport slot (
        input  write_data, write_enable, good_packet, bad_packet, flags, identification, pop,
        output ready, full, read_data, read_valid, last, data_ready, current_flags,
        output current_identification
    );

endinterface

// File: rtl/slot_write_steer.sv
module slot_write_steer #(
    parameter int  NUM_SLOTS   = 4,
    localparam int INDEX_WIDTH = $clog2(NUM_SLOTS)
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  rx_buffer_pkg::rx_byte_t in_data,
    input  logic                    in_valid,
    input  logic                    in_good,
    input  logic                    in_bad,
    input  ipv4_pkg::ipv4_flags_u   in_flags,
    input  ipv4_pkg::ipv4_ident_t   in_identification,
    output logic                    in_ready,
    slot_if.steer                   slots [NUM_SLOTS]
);

    logic [INDEX_WIDTH-1:0] current_slot;
    logic [INDEX_WIDTH-1:0] next_slot;
    logic [INDEX_WIDTH-1:0] candidate;
    logic [NUM_SLOTS-1:0]   slot_ready;
    logic [NUM_SLOTS-1:0]   slot_full;
    logic [NUM_SLOTS-1:0]   slot_select;
    logic                   commit_good;
    logic                   commit_bad;
    logic                   found;
    logic                   advance;

    // Reserved bit set means drop, whatever the parser said
    assign commit_good = in_good && !in_flags.fields.reserved;
    assign commit_bad  = in_bad || (in_good && in_flags.fields.reserved);

    assign in_ready = slot_ready[current_slot] && !slot_full[current_slot];

    ////////////////////////////////////////
    // Round-robin search for an idle slot
    ////////////////////////////////////////

    // Current slot is tried last, and skipped when it is committing now
    always_comb begin
        next_slot = current_slot;
        candidate = current_slot;
        found     = 1'b0;
        for (int k = 1; k <= NUM_SLOTS; k++) begin
            candidate = INDEX_WIDTH'((int'(current_slot) + k) % NUM_SLOTS);
            if (!found && slot_ready[candidate] &&
                    !(candidate == current_slot && commit_good)) begin
                next_slot = candidate;
                found     = 1'b1;
            end
        end
    end

    // Re-search after every verdict and while parked on a busy slot
    assign advance = in_good || in_bad || !slot_ready[current_slot];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            current_slot <= '0;
        end else if (advance) begin
            current_slot <= next_slot;
        end
    end

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        assign slot_select[i] = (current_slot == INDEX_WIDTH'(i));
        assign slot_ready[i]  = slots[i].ready;
        assign slot_full[i]   = slots[i].full;

        assign slots[i].write_data     = in_data;
        assign slots[i].write_enable   = in_valid && in_ready && slot_select[i];
        assign slots[i].good_packet    = commit_good && slot_select[i];
        assign slots[i].bad_packet     = commit_bad && slot_select[i];
        assign slots[i].flags          = in_flags;
        assign slots[i].identification = in_identification;
    end

    assert property (@(posedge clock) disable iff (!reset_n) !(in_good && in_bad));

endmodule

// File: rtl/synchronous_fifo.sv
module synchronous_fifo #(
    parameter int  DEPTH       = 64,
    localparam int ADDR_WIDTH  = $clog2(DEPTH),
    localparam int COUNT_WIDTH = $clog2(DEPTH) + 1
) (
    input  logic                    clock,
    input  logic                    reset_n,
    input  logic                    flush,
    input  logic                    write_enable,
    input  rx_buffer_pkg::rx_byte_t write_data,
    input  logic                    read_enable,
    output rx_buffer_pkg::rx_byte_t read_data,
    output logic                    read_valid,
    output logic                    full,
    output logic                    empty,
    output logic [COUNT_WIDTH-1:0]  count
);

    rx_buffer_pkg::rx_byte_t memory [DEPTH];

    logic [ADDR_WIDTH-1:0] write_pointer;
    logic [ADDR_WIDTH-1:0] read_pointer;
    logic                  do_write;
    logic                  do_read;

    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    assign full  = (count == COUNT_WIDTH'(DEPTH));
    assign empty = (count == '0);

    // Head of the queue is always on the output
    assign read_data  = memory[read_pointer];
    assign read_valid = !empty;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
    end

    ////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////

    // Depth is a power of two so the pointers wrap by themselves
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else if (flush) begin
            // Drop everything, contents are left stale
            write_pointer <= '0;
            read_pointer  <= '0;
            count         <= '0;
        end else begin
            if (do_write) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (do_read) begin
                read_pointer <= read_pointer + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Upstream must honour full through in_ready
    assert property (@(posedge clock) disable iff (!reset_n) write_enable |-> !full);

    // Arbiter pops only on a valid head byte
    assert property (@(posedge clock) disable iff (!reset_n) read_enable |-> !empty);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_ipv4_receive_buffer -Mdir obj_dir -f filelist.f &&
./obj_dir/Vtb_ipv4_receive_buffer ||
{ echo "simulation did not complete successfully"; exit 1; }

// File: sim/tb_ipv4_receive_buffer.sv
module tb_ipv4_receive_buffer;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_SLOTS  = 4;
    localparam int SLOT_DEPTH = 64;
    localparam int TIMEOUT    = 2000;

    logic                    clock;
    logic                    reset_n;
    rx_buffer_pkg::rx_byte_t in_data;
    logic                    in_valid;
    logic                    in_ready;
    logic                    in_good;
    logic                    in_bad;
    ipv4_pkg::ipv4_flags_u   in_flags;
    ipv4_pkg::ipv4_ident_t   in_identification;
    rx_buffer_pkg::rx_byte_t out_data;
    logic                    out_valid;
    logic                    out_ready;
    logic                    out_last;
    ipv4_pkg::ipv4_flags_u   out_flags;
    ipv4_pkg::ipv4_ident_t   out_identification;

    logic [31:0] rng_state;

    // Packets still expected at the output in send order
    rx_buffer_pkg::rx_byte_t expected_bytes   [$];
    int                      expected_lengths [$];
    ipv4_pkg::ipv4_flags_u   expected_flags   [$];
    ipv4_pkg::ipv4_ident_t   expected_idents  [$];

    ipv4_receive_buffer i_ipv4_receive_buffer (
        .clock              (clock),
        .reset_n            (reset_n),
        .in_data            (in_data),
        .in_valid           (in_valid),
        .in_ready           (in_ready),
        .in_good            (in_good),
        .in_bad             (in_bad),
        .in_flags           (in_flags),
        .in_identification  (in_identification),
        .out_data           (out_data),
        .out_valid          (out_valid),
        .out_ready          (out_ready),
        .out_last           (out_last),
        .out_flags          (out_flags),
        .out_identification (out_identification)
    );

    always #2 clock = ~clock;

    ////////////////////////////////////////
    // Random numbers and failure handling
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Any header word with the reserved bit cleared
    function automatic ipv4_pkg::ipv4_flags_u random_flags();
        ipv4_pkg::ipv4_flags_u flags;
        flags.raw             = 16'(xorshift());
        flags.fields.reserved = 1'b0;
        return flags;
    endfunction

    task automatic stop_with_failure();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_byte(rx_buffer_pkg::rx_byte_t actual, rx_buffer_pkg::rx_byte_t expected,
                              string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flags(ipv4_pkg::ipv4_flags_u actual, ipv4_pkg::ipv4_flags_u expected,
                               string what);
        if (actual.raw !== expected.raw) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual.raw,
                     expected.raw);
            stop_with_failure();
        end
    endtask

    task automatic check_ident(ipv4_pkg::ipv4_ident_t actual, ipv4_pkg::ipv4_ident_t expected,
                               string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_last(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // Stream control levels such as in_ready and out_valid
    task automatic check_level(logic actual, logic expected, string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////////////
    // Drivers
    ////////////////////////////////////////

    // Bytes go in one by one as in_ready allows, then a one-cycle verdict
    task automatic send_packet(int length, ipv4_pkg::ipv4_flags_u flags,
                               ipv4_pkg::ipv4_ident_t ident, bit good, bit delivered);
        rx_buffer_pkg::rx_byte_t value;
        int                      waited;
        for (int i = 0; i < length; i++) begin
            value = rx_buffer_pkg::rx_byte_t'(xorshift());
            if (delivered) begin
                expected_bytes.push_back(value);
            end
            @(negedge clock);
            in_data  = value;
            in_valid = 1'b1;
            waited   = 0;
            while (!in_ready) begin
                @(negedge clock);
                waited++;
                if (waited > TIMEOUT) begin
                    $display("Timeout: in_ready never rose while sending a packet byte");
                    stop_with_failure();
                end
            end
        end
        @(negedge clock);
        in_valid          = 1'b0;
        in_good           = good;
        in_bad            = !good;
        in_flags          = flags;
        in_identification = ident;
        @(negedge clock);
        in_good = 1'b0;
        in_bad  = 1'b0;
        if (delivered) begin
            expected_lengths.push_back(length);
            expected_flags.push_back(flags);
            expected_idents.push_back(ident);
        end
    endtask

    // Takes the oldest expected packet
    // out_ready is high in ready_percent of the cycles
    task automatic receive_packet(int ready_percent);
        int                    length;
        int                    waited;
        bit                    taken;
        ipv4_pkg::ipv4_flags_u flags;
        ipv4_pkg::ipv4_ident_t ident;
        if (expected_lengths.size() == 0) begin
            $display("Receive requested with no packet left to expect");
            stop_with_failure();
        end
        length = expected_lengths.pop_front();
        flags  = expected_flags.pop_front();
        ident  = expected_idents.pop_front();
        for (int i = 0; i < length; i++) begin
            waited = 0;
            taken  = 1'b0;
            while (!taken) begin
                @(negedge clock);
                out_ready = ((xorshift() % 100) < ready_percent);
                if (out_valid && out_ready) begin
                    check_byte(out_data, expected_bytes.pop_front(), "out_data");
                    check_flags(out_flags, flags, "out_flags");
                    check_ident(out_identification, ident, "out_identification");
                    check_last(out_last, (i == length - 1), "out_last");
                    taken = 1'b1;
                end else begin
                    waited++;
                    if (waited > TIMEOUT) begin
                        $display("Timeout: no output byte arrived for an expected packet");
                        stop_with_failure();
                    end
                end
            end
        end
        // Hold off the next packet until the next receive
        @(negedge clock);
        out_ready = 1'b0;
    endtask

    task automatic expect_no_output(int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_level(out_valid, 1'b0, "out_valid with nothing committed");
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic test_single_packet();
        ipv4_pkg::ipv4_flags_u flags;
        flags.raw                  = '0;
        flags.fields.dont_fragment = 1'b1;
        send_packet(20, flags, 16'h1c46, 1'b1, 1'b1);
        receive_packet(100);
        expect_no_output(10);
    endtask

    task automatic test_bad_flush();
        send_packet(15, random_flags(), 16'h0bad, 1'b0, 1'b0);
        send_packet(9, random_flags(), 16'h600d, 1'b1, 1'b1);
        receive_packet(100);
        expect_no_output(10);
    endtask

    task automatic test_reserved_flag();
        ipv4_pkg::ipv4_flags_u flags;
        flags                 = random_flags();
        flags.fields.reserved = 1'b1;
        // Parser says good, but the reserved bit still drops it
        send_packet(12, flags, 16'he411, 1'b1, 1'b0);
        send_packet(7, random_flags(), 16'h2222, 1'b1, 1'b1);
        receive_packet(100);
        expect_no_output(10);
    endtask

    task automatic test_commit_order();
        for (int p = 0; p < NUM_SLOTS; p++) begin
            send_packet(1 + int'(xorshift() % SLOT_DEPTH), random_flags(),
                        ipv4_pkg::ipv4_ident_t'(xorshift()), 1'b1, 1'b1);
        end
        repeat (2) @(negedge clock);
        check_level(in_ready, 1'b0, "in_ready with every slot committed");
        for (int p = 0; p < NUM_SLOTS; p++) begin
            receive_packet(100);
        end
        expect_no_output(10);
    endtask

    task automatic test_back_pressure();
        for (int round = 0; round < 3; round++) begin
            for (int p = 0; p < 3; p++) begin
                send_packet(1 + int'(xorshift() % SLOT_DEPTH), random_flags(),
                            ipv4_pkg::ipv4_ident_t'(xorshift()), 1'b1, 1'b1);
            end
            for (int p = 0; p < 3; p++) begin
                receive_packet(50);
            end
        end
        expect_no_output(10);
    endtask

    initial begin
        rng_state         = 32'd12;
        clock             = 1'b0;
        reset_n           = 1'b0;
        in_data           = '0;
        in_valid          = 1'b0;
        in_good           = 1'b0;
        in_bad            = 1'b0;
        in_flags          = '0;
        in_identification = '0;
        out_ready         = 1'b0;

        repeat (10) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        test_single_packet();
        test_bad_flush();
        test_reserved_flag();
        test_commit_order();
        test_back_pressure();

        $display("sim passed");
        $finish;
    end

endmodule
